// File: testbench/udp_rx_cases.txt
// dst_mac ethertype ver_ihl proto dst_ip dst_port src_ip src_port pay_words end(1=bad) accept mode
// mode 0 normal, 1 chained to next frame, 2 ack held low, 3 local_enable low, 4 phy down
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a000001 c350 1 0 1 0
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a000002 c351 4 0 1 0
ffffffffffff 0800 45 11 c0a80a01 1388 0a000003 0035 c 0 1 0
// Header checks that reject the frame
020a0b0c0d0f 0800 45 11 c0a80a01 1388 0a000004 1000 3 0 0 0
020a0b0c0d0e 86dd 45 11 c0a80a01 1388 0a000005 1001 3 0 0 0
020a0b0c0d0e 0800 46 11 c0a80a01 1388 0a000006 1002 3 0 0 0
020a0b0c0d0e 0800 45 06 c0a80a01 1388 0a000007 1003 3 0 0 0
020a0b0c0d0e 0800 45 11 c0a80a02 1388 0a000008 1004 3 0 0 0
020a0b0c0d0e 0800 45 11 c0a80a01 1389 0a000009 1005 3 0 0 0
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a00000a 1006 3 0 0 3
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a00000b 1007 3 0 0 4
// Bad end
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a00000c 1008 5 1 1 0
// Overrun with 70 payload words, then a frame that must arrive complete
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a00000d 1009 46 0 1 2
020a0b0c0d0e 0800 45 11 c0a80a01 1388 0a00000e 100a 8 0 1 0
// Back to back frames
020a0b0c0d0e 0800 45 11 c0a80a01 1388 ac100001 2000 3 0 1 1
020a0b0c0d0e 0800 45 11 c0a80a01 1388 ac100002 2001 6 0 1 1
020a0b0c0d0e 0800 45 06 c0a80a01 1388 ac100003 2002 2 0 0 1
ffffffffffff 0800 45 11 c0a80a01 1388 ac100004 2003 2 1 1 1
020a0b0c0d0e 0800 45 11 c0a80a01 1388 ac100005 2004 4 0 1 0
ffffffffffff 0800 45 11 c0a80a01 1388 c0a80aff 2005 1 1 1 0

// File: all.f
src/udp_rx_proto_pkg.sv
src/udp_rx_buf_pkg.sv
src/sync_fifo.sv
src/udp_frame_parser.sv
src/udp_payload_writer.sv
src/udp_rx.sv
testbench/tb_udp_rx.sv

// File: testbench/tb_udp_rx.sv
`timescale 1ns/1ns

module tb_udp_rx;

  localparam int CLK_PERIOD = 8;
  localparam int MAX_CASES  = 32;
  localparam int NUM_FIELDS = 12;
  localparam int MAX_BYTES  = 1024;

  // Column positions in the cases file
  localparam int F_DST_MAC   = 0;
  localparam int F_ETYPE     = 1;
  localparam int F_VER_IHL   = 2;
  localparam int F_PROTO     = 3;
  localparam int F_DST_IP    = 4;
  localparam int F_DST_PORT  = 5;
  localparam int F_SRC_IP    = 6;
  localparam int F_SRC_PORT  = 7;
  localparam int F_PAY_WORDS = 8;
  localparam int F_BAD_END   = 9;
  localparam int F_ACCEPT    = 10;
  localparam int F_MODE      = 11;

  localparam int MODE_CHAIN     = 1;
  localparam int MODE_STALL     = 2;
  localparam int MODE_LOCAL_OFF = 3;
  localparam int MODE_PHY_DOWN  = 4;

  logic        mac_clk;
  logic        mac_rst;
  logic [63:0] mac_rx_data;
  logic [7:0]  mac_rx_data_valid;
  logic        mac_rx_good_frame;
  logic        mac_rx_bad_frame;
  logic        phy_rx_up;
  logic        local_enable;
  logic        app_rx_ack;
  logic        app_rx_overrun_ack;
  logic        app_rx_valid;
  logic        app_rx_end_of_frame;
  logic [63:0] app_rx_data;
  logic [31:0] app_rx_source_ip;
  logic [15:0] app_rx_source_port;
  logic        app_rx_bad_frame;
  logic        app_rx_overrun;

  logic [47:0] case_mem [0:MAX_CASES*NUM_FIELDS-1];
  logic [7:0]  frame_bytes [0:MAX_BYTES-1];
  int          frame_words;
  int          case_err [0:MAX_CASES-1];
  int          n_cases;
  int          total_words;
  int          watchdog_cycles;
  logic        cases_loaded;
  integer      seed;
  int          errors;
  int          checks;
  int          failed_tests;
  int          cur_case;
  logic        drain_en;

  // Fields of the case being driven
  logic [47:0] hdr_dst_mac;
  logic [15:0] hdr_ethertype;
  logic [7:0]  hdr_ver_ihl;
  logic [7:0]  hdr_proto;
  logic [31:0] hdr_dst_ip;
  logic [15:0] hdr_dst_port;
  logic [31:0] hdr_src_ip;
  logic [15:0] hdr_src_port;
  int          pay_words;
  logic        bad_end;
  logic        accept;
  int          mode;

  // Expected application words, oldest first
  logic [63:0] exp_data [$];
  logic [2:0]  exp_flags [$];
  logic [31:0] exp_ip [$];
  logic [15:0] exp_port [$];
  int          exp_case [$];
  int          pending [$];

  udp_rx dut (
    .mac_clk             (mac_clk),
    .mac_rst             (mac_rst),
    .mac_rx_data         (mac_rx_data),
    .mac_rx_data_valid   (mac_rx_data_valid),
    .mac_rx_good_frame   (mac_rx_good_frame),
    .mac_rx_bad_frame    (mac_rx_bad_frame),
    .phy_rx_up           (phy_rx_up),
    .local_enable        (local_enable),
    .local_mac           (48'h020a0b0c0d0e),
    .local_ip            (32'hc0a80a01),
    .local_port          (16'h1388),
    .app_rx_ack          (app_rx_ack),
    .app_rx_overrun_ack  (app_rx_overrun_ack),
    .app_rx_valid        (app_rx_valid),
    .app_rx_end_of_frame (app_rx_end_of_frame),
    .app_rx_data         (app_rx_data),
    .app_rx_source_ip    (app_rx_source_ip),
    .app_rx_source_port  (app_rx_source_port),
    .app_rx_bad_frame    (app_rx_bad_frame),
    .app_rx_overrun      (app_rx_overrun)
  );

  initial begin
    mac_clk = 1'b0;
    forever #(CLK_PERIOD / 2) mac_clk = ~mac_clk;
  end

  task automatic load_case(input int c);
    int b;
    b = c * NUM_FIELDS;
    hdr_dst_mac   = case_mem[b + F_DST_MAC];
    hdr_ethertype = case_mem[b + F_ETYPE][15:0];
    hdr_ver_ihl   = case_mem[b + F_VER_IHL][7:0];
    hdr_proto     = case_mem[b + F_PROTO][7:0];
    hdr_dst_ip    = case_mem[b + F_DST_IP][31:0];
    hdr_dst_port  = case_mem[b + F_DST_PORT][15:0];
    hdr_src_ip    = case_mem[b + F_SRC_IP][31:0];
    hdr_src_port  = case_mem[b + F_SRC_PORT][15:0];
    pay_words     = case_mem[b + F_PAY_WORDS][15:0];
    bad_end       = case_mem[b + F_BAD_END][0];
    accept        = case_mem[b + F_ACCEPT][0];
    mode          = case_mem[b + F_MODE][7:0];
  endtask

  // Random bytes everywhere, then the checked header fields on top
  task automatic build_frame();
    logic [31:0] rnd;
    int i;
    frame_words = pay_words + 5;
    for (i = 0; i < frame_words * 8; i++) begin
      rnd = $random(seed);
      frame_bytes[i] = rnd[7:0];
    end
    for (i = 0; i < 6; i++) begin
      frame_bytes[i] = hdr_dst_mac[47 - 8 * i -: 8];
    end
    frame_bytes[12] = hdr_ethertype[15:8];
    frame_bytes[13] = hdr_ethertype[7:0];
    frame_bytes[14] = hdr_ver_ihl;
    frame_bytes[23] = hdr_proto;
    for (i = 0; i < 4; i++) begin
      frame_bytes[26 + i] = hdr_src_ip[31 - 8 * i -: 8];
      frame_bytes[30 + i] = hdr_dst_ip[31 - 8 * i -: 8];
    end
    frame_bytes[34] = hdr_src_port[15:8];
    frame_bytes[35] = hdr_src_port[7:0];
    frame_bytes[36] = hdr_dst_port[15:8];
    frame_bytes[37] = hdr_dst_port[7:0];
  endtask

  // Payload starts at byte 42, zero filled past the frame end
  task automatic model_frame(input int c);
    logic [63:0] word;
    logic        stalled;
    logic        last;
    logic        ovr;
    int          n_out;
    int          k;
    int          j;
    int          idx;
    stalled = (mode == MODE_STALL);
    n_out   = pay_words;
    // With ack low the word written at the threshold ends the frame early
    if (stalled && pay_words > udp_rx_buf_pkg::PAYLOAD_AFULL) begin
      n_out = udp_rx_buf_pkg::PAYLOAD_AFULL + 1;
    end
    for (k = 0; k < n_out; k++) begin
      for (j = 0; j < 8; j++) begin
        idx = 42 + 8 * k + j;
        word[8*j +: 8] = (idx < frame_words * 8) ? frame_bytes[idx] : 8'h00;
      end
      last = (k == pay_words - 1);
      ovr  = stalled && (k == udp_rx_buf_pkg::PAYLOAD_AFULL);
      exp_data.push_back(word);
      exp_flags.push_back({ovr, last && bad_end, last || ovr});
      exp_ip.push_back(hdr_src_ip);
      exp_port.push_back(hdr_src_port);
      exp_case.push_back(c);
    end
  endtask

  task automatic send_frame();
    int w;
    int j;
    for (w = 0; w < frame_words; w++) begin
      @(negedge mac_clk);
      for (j = 0; j < 8; j++) begin
        mac_rx_data[8*j +: 8] = frame_bytes[8 * w + j];
      end
      mac_rx_data_valid = 8'hff;
    end
    // End pulse arrives with valid low and stale bytes on the data lanes
    @(negedge mac_clk);
    mac_rx_data       = '1;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = !bad_end;
    mac_rx_bad_frame  = bad_end;
    @(negedge mac_clk);
    mac_rx_data       = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
  endtask

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int id);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t ns %s got %h expected %h", $time, name, got, exp);
      errors++;
      case_err[id]++;
    end
  endtask

  task automatic check_word();
    logic [63:0] data;
    logic [2:0]  flags;
    logic [31:0] ip;
    logic [15:0] port;
    int          id;
    checks++;
    assert (exp_data.size() > 0) else begin
      $display("Unexpected payload word %h at %0t ns, no frame should be giving output",
               app_rx_data, $time);
      errors++;
      case_err[cur_case]++;
    end
    if (exp_data.size() > 0) begin
      data  = exp_data.pop_front();
      flags = exp_flags.pop_front();
      ip    = exp_ip.pop_front();
      port  = exp_port.pop_front();
      id    = exp_case.pop_front();
      compare_field("app_rx_data", app_rx_data, data, id);
      compare_field("app_rx_end_of_frame", app_rx_end_of_frame, flags[0], id);
      compare_field("app_rx_bad_frame", app_rx_bad_frame, flags[1], id);
      compare_field("app_rx_overrun", app_rx_overrun, flags[2], id);
      compare_field("app_rx_source_ip", app_rx_source_ip, ip, id);
      compare_field("app_rx_source_port", app_rx_source_port, port, id);
    end
  endtask

  // Ack goes out with the word it pops on the next rising edge
  always @(negedge mac_clk) begin
    if (mac_rst || !drain_en) begin
      app_rx_ack = 1'b0;
    end else begin
      app_rx_ack = 1'b1;
      if (app_rx_valid) begin
        check_word();
      end
    end
  end

  task automatic wait_idle();
    while (exp_data.size() != 0) begin
      @(negedge mac_clk);
    end
    // Quiet window so that extra words still get caught
    repeat (12) @(negedge mac_clk);
  endtask

  task automatic pulse_overrun_ack();
    @(negedge mac_clk);
    app_rx_overrun_ack = 1'b1;
    @(negedge mac_clk);
    app_rx_overrun_ack = 1'b0;
  endtask

  task automatic report_pending();
    int p;
    while (pending.size() > 0) begin
      p = pending.pop_front();
      $display("Test %0d: mode %0d, %0d payload words, %s, %0d errors", p + 1,
               case_mem[p * NUM_FIELDS + F_MODE], case_mem[p * NUM_FIELDS + F_PAY_WORDS],
               case_mem[p * NUM_FIELDS + F_ACCEPT] ? "accepted" : "rejected", case_err[p]);
      if (case_err[p] != 0) begin
        failed_tests++;
      end
    end
  endtask

  initial begin
    wait (cases_loaded);
    #(watchdog_cycles * CLK_PERIOD);
    $display("Timeout: the run was still busy after %0d cycles", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int c;
    mac_rst            = 1'b1;
    mac_rx_data        = '0;
    mac_rx_data_valid  = '0;
    mac_rx_good_frame  = 1'b0;
    mac_rx_bad_frame   = 1'b0;
    phy_rx_up          = 1'b1;
    local_enable       = 1'b1;
    app_rx_ack         = 1'b0;
    app_rx_overrun_ack = 1'b0;
    drain_en           = 1'b1;
    cases_loaded       = 1'b0;
    seed               = 32'ha2a88341;
    errors             = 0;
    checks             = 0;
    failed_tests       = 0;
    cur_case           = 0;
    for (c = 0; c < MAX_CASES; c++) begin
      case_err[c] = 0;
    end
    $readmemh("testbench/udp_rx_cases.txt", case_mem);
    n_cases     = 0;
    total_words = 0;
    while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases * NUM_FIELDS])) begin
      total_words += case_mem[n_cases * NUM_FIELDS + F_PAY_WORDS][15:0] + 5;
      n_cases++;
    end
    watchdog_cycles = total_words * 4 + 2000;
    cases_loaded    = 1'b1;
    repeat (10) @(negedge mac_clk);
    mac_rst = 1'b0;
    repeat (4) @(negedge mac_clk);
    assert (n_cases > 0) else begin
      $display("No test cases were read from the cases file");
      errors++;
    end
    for (c = 0; c < n_cases; c++) begin
      load_case(c);
      build_frame();
      cur_case <= c;
      pending.push_back(c);
      if (accept) begin
        model_frame(c);
      end
      if (mode == MODE_STALL) begin
        drain_en <= 1'b0;
      end
      local_enable = (mode != MODE_LOCAL_OFF);
      phy_rx_up    = (mode != MODE_PHY_DOWN);
      send_frame();
      local_enable = 1'b1;
      phy_rx_up    = 1'b1;
      if (mode == MODE_STALL) begin
        repeat (4) @(negedge mac_clk);
        drain_en <= 1'b1;
        wait_idle();
        pulse_overrun_ack();
      end
      // Chained frames go out back to back and are reported together
      if (mode != MODE_CHAIN) begin
        wait_idle();
        report_pending();
      end
    end
    wait_idle();
    report_pending();
    $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
             n_cases, failed_tests, checks, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src/udp_rx.sv
`timescale 1ns/1ns

module udp_rx (
  input  logic                        mac_clk,
  input  logic                        mac_rst,
  input  logic [63:0]                 mac_rx_data,
  input  logic [7:0]                  mac_rx_data_valid,
  input  logic                        mac_rx_good_frame,
  input  logic                        mac_rx_bad_frame,
  input  logic                        phy_rx_up,
  input  logic                        local_enable,
  input  udp_rx_proto_pkg::mac_addr_t local_mac,
  input  udp_rx_proto_pkg::ip_addr_t  local_ip,
  input  udp_rx_proto_pkg::udp_port_t local_port,
  input  logic                        app_rx_ack,
  input  logic                        app_rx_overrun_ack,
  output logic                        app_rx_valid,
  output logic                        app_rx_end_of_frame,
  output logic [63:0]                 app_rx_data,
  output udp_rx_proto_pkg::ip_addr_t  app_rx_source_ip,
  output udp_rx_proto_pkg::udp_port_t app_rx_source_port,
  output logic                        app_rx_bad_frame,
  output logic                        app_rx_overrun
);

  // Parser to writer
  logic                                       pay_valid;
  logic [63:0]                                pay_data;
  logic                                       pay_last;
  logic                                       pay_bad;
  udp_rx_proto_pkg::ip_addr_t                 src_ip;
  udp_rx_proto_pkg::udp_port_t                src_port;

  // Writer to FIFOs
  logic                                       pay_wr_en;
  logic [udp_rx_buf_pkg::PAYLOAD_ENTRY_W-1:0] pay_wr_data;
  logic                                       pay_afull;
  logic                                       ctrl_wr_en;
  logic [udp_rx_buf_pkg::CTRL_ENTRY_W-1:0]    ctrl_wr_data;
  logic                                       ctrl_afull;

  // FIFOs to application
  logic [udp_rx_buf_pkg::PAYLOAD_ENTRY_W-1:0] pay_rd_data;
  logic                                       pay_empty;
  logic [udp_rx_buf_pkg::CTRL_ENTRY_W-1:0]    ctrl_rd_data;
  logic                                       ctrl_rd_en;

  udp_frame_parser u_parser (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .phy_rx_up         (phy_rx_up),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .pay_valid         (pay_valid),
    .pay_data          (pay_data),
    .pay_last          (pay_last),
    .pay_bad           (pay_bad),
    .src_ip            (src_ip),
    .src_port          (src_port)
  );

  udp_payload_writer u_writer (
    .mac_clk            (mac_clk),
    .mac_rst            (mac_rst),
    .pay_valid          (pay_valid),
    .pay_data           (pay_data),
    .pay_last           (pay_last),
    .pay_bad            (pay_bad),
    .src_ip             (src_ip),
    .src_port           (src_port),
    .pay_afull          (pay_afull),
    .ctrl_afull         (ctrl_afull),
    .app_rx_overrun_ack (app_rx_overrun_ack),
    .pay_wr_en          (pay_wr_en),
    .pay_wr_data        (pay_wr_data),
    .ctrl_wr_en         (ctrl_wr_en),
    .ctrl_wr_data       (ctrl_wr_data)
  );

  sync_fifo #(
    .DEPTH (udp_rx_buf_pkg::PAYLOAD_DEPTH),
    .WIDTH (udp_rx_buf_pkg::PAYLOAD_ENTRY_W),
    .AFULL (udp_rx_buf_pkg::PAYLOAD_AFULL)
  ) u_pay_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (pay_wr_en),
    .wr_data     (pay_wr_data),
    .rd_en       (app_rx_ack),
    .rd_data     (pay_rd_data),
    .empty       (pay_empty),
    .almost_full (pay_afull)
  );

  sync_fifo #(
    .DEPTH (udp_rx_buf_pkg::CTRL_DEPTH),
    .WIDTH (udp_rx_buf_pkg::CTRL_ENTRY_W),
    .AFULL (udp_rx_buf_pkg::CTRL_AFULL)
  ) u_ctrl_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     (ctrl_wr_data),
    .rd_en       (ctrl_rd_en),
    .rd_data     (ctrl_rd_data),
    .empty       (),
    .almost_full (ctrl_afull)
  );

  assign app_rx_valid        = !pay_empty;
  assign app_rx_data         = pay_rd_data[udp_rx_buf_pkg::EOF_BIT-1:0];
  assign app_rx_end_of_frame = pay_rd_data[udp_rx_buf_pkg::EOF_BIT];
  assign app_rx_bad_frame    = pay_rd_data[udp_rx_buf_pkg::BAD_BIT];
  assign app_rx_overrun      = pay_rd_data[udp_rx_buf_pkg::OVR_BIT];

  assign app_rx_source_ip   = ctrl_rd_data[$bits(udp_rx_proto_pkg::ip_addr_t)-1:0];
  assign app_rx_source_port =
    ctrl_rd_data[udp_rx_buf_pkg::CTRL_ENTRY_W-1 -: $bits(udp_rx_proto_pkg::udp_port_t)];

  // Control entry retires with the last word of its frame
  assign ctrl_rd_en = app_rx_ack && app_rx_valid && app_rx_end_of_frame;

endmodule

// File: src/udp_payload_writer.sv
`timescale 1ns/1ns

module udp_payload_writer (
  input  logic                                       mac_clk,
  input  logic                                       mac_rst,
  input  logic                                       pay_valid,
  input  logic [63:0]                                pay_data,
  input  logic                                       pay_last,
  input  logic                                       pay_bad,
  input  udp_rx_proto_pkg::ip_addr_t                 src_ip,
  input  udp_rx_proto_pkg::udp_port_t                src_port,
  input  logic                                       pay_afull,
  input  logic                                       ctrl_afull,
  input  logic                                       app_rx_overrun_ack,
  output logic                                       pay_wr_en,
  output logic [udp_rx_buf_pkg::PAYLOAD_ENTRY_W-1:0] pay_wr_data,
  output logic                                       ctrl_wr_en,
  output logic [udp_rx_buf_pkg::CTRL_ENTRY_W-1:0]    ctrl_wr_data
);

  logic afull;
  logic in_run;
  // Overrun states, run is neither flag set
  logic over_st;
  logic wait_st;
  logic first_word;
  logic open_q;
  logic frame_open;
  logic ovr_hit;

  assign afull   = pay_afull || ctrl_afull;
  assign in_run  = !over_st && !wait_st;
  assign ovr_hit = in_run && pay_valid && afull;

  // Whether a frame is still running after this cycle
  assign frame_open = pay_valid ? !pay_last : open_q;

  assign pay_wr_en    = in_run && pay_valid;
  assign ctrl_wr_en   = pay_wr_en && first_word;
  assign ctrl_wr_data = {src_port, src_ip};

  // An overrun word also ends the frame for the application
  always_comb begin
    pay_wr_data[udp_rx_buf_pkg::EOF_BIT-1:0] = pay_data;
    pay_wr_data[udp_rx_buf_pkg::EOF_BIT]     = pay_last || afull;
    pay_wr_data[udp_rx_buf_pkg::BAD_BIT]     = pay_last && pay_bad;
    pay_wr_data[udp_rx_buf_pkg::OVR_BIT]     = afull;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      over_st    <= 1'b0;
      wait_st    <= 1'b0;
      open_q     <= 1'b0;
      first_word <= 1'b1;
    end else begin
      if (pay_wr_en) begin
        first_word <= pay_last || afull;
      end
      if (ovr_hit) begin
        over_st <= 1'b1;
        open_q  <= frame_open;
      end else if (over_st) begin
        // Drop everything until the application has seen the overrun
        open_q <= frame_open;
        if (app_rx_overrun_ack) begin
          over_st <= 1'b0;
          wait_st <= frame_open;
        end
      end else if (wait_st && pay_valid && pay_last) begin
        wait_st <= 1'b0;
      end
    end
  end

endmodule

// File: src/udp_frame_parser.sv
`timescale 1ns/1ns

module udp_frame_parser (
  input  logic                        mac_clk,
  input  logic                        mac_rst,
  input  logic [63:0]                 mac_rx_data,
  input  logic [7:0]                  mac_rx_data_valid,
  input  logic                        mac_rx_good_frame,
  input  logic                        mac_rx_bad_frame,
  input  logic                        phy_rx_up,
  input  logic                        local_enable,
  input  udp_rx_proto_pkg::mac_addr_t local_mac,
  input  udp_rx_proto_pkg::ip_addr_t  local_ip,
  input  udp_rx_proto_pkg::udp_port_t local_port,
  output logic                        pay_valid,
  output logic [63:0]                 pay_data,
  output logic                        pay_last,
  output logic                        pay_bad,
  output udp_rx_proto_pkg::ip_addr_t  src_ip,
  output udp_rx_proto_pkg::udp_port_t src_port
);

  udp_rx_proto_pkg::hdr_word_u    cur_w;
  udp_rx_proto_pkg::hdr_word_u    prev_w;
  logic [7:0]                     valid_q;
  logic                           good_q;
  logic                           bad_q;
  logic                           frame_word;
  logic                           frame_end;
  logic                           in_payload;
  udp_rx_proto_pkg::parse_state_e state;

  udp_rx_proto_pkg::mac_addr_t    dst_mac;
  logic [15:0]                    ethertype;
  udp_rx_proto_pkg::ip_addr_t     dst_ip;
  udp_rx_proto_pkg::udp_port_t    dst_port;
  logic [63:0]                    realigned;

  // Registered MAC word plus the word before it
  always_ff @(posedge mac_clk) begin
    cur_w  <= mac_rx_data;
    prev_w <= cur_w;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      valid_q <= '0;
      good_q  <= 1'b0;
      bad_q   <= 1'b0;
    end else begin
      valid_q <= mac_rx_data_valid;
      good_q  <= mac_rx_good_frame;
      bad_q   <= mac_rx_bad_frame;
    end
  end

  assign frame_word = &valid_q;
  assign frame_end  = good_q || bad_q;
  assign in_payload = state == udp_rx_proto_pkg::PS_PAYLOAD;

  // Header fields, swapped into network byte order
  assign dst_mac   = {<<8{cur_w.w1.dst_mac}};
  assign ethertype = {<<8{cur_w.w2.ethertype}};
  assign dst_port  = {<<8{cur_w.w5.dst_port}};
  // Destination IP straddles header words 4 and 5
  assign dst_ip    = {<<8{{cur_w.w5.dst_ip_lo, prev_w.w4.dst_ip_hi}}};

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state <= udp_rx_proto_pkg::PS_IDLE;
    end else begin
      case (state)
        udp_rx_proto_pkg::PS_IDLE: begin
          if (frame_word && phy_rx_up) begin
            if (dst_mac == local_mac || dst_mac == udp_rx_proto_pkg::BROADCAST_MAC) begin
              state <= udp_rx_proto_pkg::PS_HDR2;
            end else begin
              state <= udp_rx_proto_pkg::PS_DISCARD;
            end
          end
        end
        udp_rx_proto_pkg::PS_HDR2: begin
          if (ethertype == udp_rx_proto_pkg::ETHERTYPE_IPV4 &&
              cur_w.w2.ver_ihl == udp_rx_proto_pkg::IPV4_VER_IHL) begin
            state <= udp_rx_proto_pkg::PS_HDR3;
          end else begin
            state <= udp_rx_proto_pkg::PS_DISCARD;
          end
        end
        udp_rx_proto_pkg::PS_HDR3: begin
          if (cur_w.w3.protocol == udp_rx_proto_pkg::IP_PROTO_UDP) begin
            state <= udp_rx_proto_pkg::PS_HDR4;
          end else begin
            state <= udp_rx_proto_pkg::PS_DISCARD;
          end
        end
        udp_rx_proto_pkg::PS_HDR4: begin
          // No IP checksum check
          state <= udp_rx_proto_pkg::PS_HDR5;
        end
        udp_rx_proto_pkg::PS_HDR5: begin
          if (dst_ip == local_ip && dst_port == local_port) begin
            state <= udp_rx_proto_pkg::PS_HDR6;
          end else begin
            state <= udp_rx_proto_pkg::PS_DISCARD;
          end
        end
        udp_rx_proto_pkg::PS_HDR6: begin
          // Last gate before the payload is forwarded
          if (local_enable) begin
            state <= udp_rx_proto_pkg::PS_PAYLOAD;
          end else begin
            state <= udp_rx_proto_pkg::PS_DISCARD;
          end
        end
        default: begin
          // Payload and discard both run to the end pulse
        end
      endcase
      // End pulse closes the frame from any state
      if (frame_end) begin
        state <= udp_rx_proto_pkg::PS_IDLE;
      end
    end
  end

  // Source address fields held for the writer
  always_ff @(posedge mac_clk) begin
    if (state == udp_rx_proto_pkg::PS_HDR4) begin
      src_ip <= {<<8{cur_w.w4.src_ip}};
    end
    if (state == udp_rx_proto_pkg::PS_HDR5) begin
      src_port <= {<<8{cur_w.w5.src_port}};
    end
  end

  // Payload lanes shifted down by two bytes, lane order kept
  always_comb begin
    realigned = {cur_w.raw[udp_rx_proto_pkg::PAYLOAD_OFFSET-1:0],
                 prev_w.raw[udp_rx_proto_pkg::WORD_BYTES-1:udp_rx_proto_pkg::PAYLOAD_OFFSET]};
    // Flush word has nothing after the final frame word
    if (frame_end) begin
      realigned[63 -: udp_rx_proto_pkg::PAYLOAD_OFFSET * 8] = '0;
    end
  end

  always_ff @(posedge mac_clk) begin
    pay_data <= realigned;
    pay_bad  <= bad_q;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      pay_valid <= 1'b0;
      pay_last  <= 1'b0;
    end else begin
      pay_valid <= in_payload && (frame_word || frame_end);
      pay_last  <= in_payload && frame_end;
    end
  end

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 8,
  parameter int AFULL = 12
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       full;
  logic                       do_wr;
  logic                       do_rd;

  assign full        = count == DEPTH;
  assign empty       = count == '0;
  assign almost_full = count >= AFULL;

  // Writes when full and reads when empty are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Show-ahead, head entry always on the output
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/udp_rx_buf_pkg.sv
package udp_rx_buf_pkg;

  // Payload FIFO, one entry per realigned payload word
  localparam int PAYLOAD_DEPTH = 64;
  localparam int PAYLOAD_AFULL = 60;

  // Control FIFO, one entry per frame
  localparam int CTRL_DEPTH = 8;
  localparam int CTRL_AFULL = 6;

  // Payload entry is 64 data bits with the flags on top
  localparam int EOF_BIT = 64;
  localparam int BAD_BIT = EOF_BIT + 1;
  localparam int OVR_BIT = BAD_BIT + 1;

  localparam int PAYLOAD_ENTRY_W = OVR_BIT + 1;

  // Source port above source IP
  localparam int CTRL_ENTRY_W = 48;

endpackage

// File: src/udp_rx_proto_pkg.sv
package udp_rx_proto_pkg;

  // Frame layout on the MAC bus, frame byte 0 sits in bits 7:0
  localparam int WORD_BYTES     = 8;
  localparam int HDR_WORDS      = 6;
  // Payload begins at byte 42, two lanes into the sixth frame word
  localparam int PAYLOAD_OFFSET = 2;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
  localparam mac_addr_t   BROADCAST_MAC  = {48{1'b1}};

  // One MAC word seen as each header word in turn.
  // Multi-byte fields keep wire order, so the first byte is in the low lane
  // and the value has to be byte-swapped before it is compared
  typedef union packed {
    // Frame bytes 0-7
    struct packed {
      logic [15:0] src_mac_hi;
      logic [47:0] dst_mac;
    } w1;
    // Frame bytes 8-15
    struct packed {
      logic [7:0]  tos;
      logic [7:0]  ver_ihl;
      logic [15:0] ethertype;
      logic [31:0] src_mac_lo;
    } w2;
    // Frame bytes 16-23
    struct packed {
      logic [7:0]  protocol;
      logic [7:0]  ttl;
      logic [47:0] len_id_frag;
    } w3;
    // Frame bytes 24-31
    struct packed {
      logic [15:0] dst_ip_hi;
      logic [31:0] src_ip;
      logic [15:0] ip_csum;
    } w4;
    // Frame bytes 32-39
    struct packed {
      logic [15:0] udp_len;
      logic [15:0] dst_port;
      logic [15:0] src_port;
      logic [15:0] dst_ip_lo;
    } w5;
    // Byte lanes, lane 0 is the earliest byte
    logic [WORD_BYTES-1:0][7:0] raw;
  } hdr_word_u;

  // Idle, header words 2 to 6, payload and discard
  typedef enum logic [$clog2(HDR_WORDS + 2)-1:0] {
    PS_IDLE,
    PS_HDR2,
    PS_HDR3,
    PS_HDR4,
    PS_HDR5,
    PS_HDR6,
    PS_PAYLOAD,
    PS_DISCARD
  } parse_state_e;

endpackage
